//--- Bender.yml
package:
  name: issue_read_operands

sources:
  - src/issue_pkg.sv
  - src/int_regfile.sv
  - src/operand_hazard.sv
  - src/issue_gate.sv
  - src/operand_select.sv
  - src/dispatch_regs.sv
  - src/issue_read_operands.sv
  - target: simulation
    files:
      - sim/tb_issue_read_operands.sv

//--- sim.f
src/issue_pkg.sv
src/int_regfile.sv
src/operand_hazard.sv
src/issue_gate.sv
src/operand_select.sv
src/dispatch_regs.sv
src/issue_read_operands.sv
sim/tb_issue_read_operands.sv

//--- sim/tb_issue_read_operands.sv
// testbench of the integer issue and read-operands stage
// drives decoded entries, keeps a shadow register file and checks the
// acknowledge, the strobes and the operands with concurrent assertions

module tb_issue_read_operands import issue_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic                  clk_i;
  logic                  rst_uarch_ni;
  logic                  flush_i;
  logic                  stall_i;
  logic                  issue_valid_i;
  logic [XLEN-1:0]       pc_i;
  logic [REG_ADDR_W-1:0] rs1_i;
  logic [REG_ADDR_W-1:0] rs2_i;
  logic [REG_ADDR_W-1:0] rd_i;
  logic [XLEN-1:0]       imm_i;
  logic                  use_imm_i;
  logic                  use_pc_i;
  logic                  use_zimm_i;
  fu_t                   fu_i;
  logic [OP_W-1:0]       op_i;
  logic [TRANS_ID_W-1:0] trans_id_i;
  logic                  ex_valid_i;
  logic                  issue_ack_o;
  fu_t [NR_REGS-1:0]     rd_clobber_i;
  logic [XLEN-1:0]       fwd_rs1_data_i;
  logic                  fwd_rs1_valid_i;
  logic [XLEN-1:0]       fwd_rs2_data_i;
  logic                  fwd_rs2_valid_i;
  logic                  flu_ready_i;
  logic                  lsu_ready_i;
  logic                  commit_we_i;
  logic [REG_ADDR_W-1:0] commit_waddr_i;
  logic [XLEN-1:0]       commit_wdata_i;
  logic                  alu_valid_o;
  logic                  branch_valid_o;
  logic                  lsu_valid_o;
  logic                  mult_valid_o;
  logic                  csr_valid_o;
  logic [XLEN-1:0]       operand_a_o;
  logic [XLEN-1:0]       operand_b_o;
  logic [XLEN-1:0]       imm_o;
  fu_t                   fu_o;
  logic [OP_W-1:0]       op_o;
  logic [TRANS_ID_W-1:0] trans_id_o;
  logic [XLEN-1:0]       pc_o;
  logic                  stall_issue_o;

  int          errors;
  int          timeouts;
  string       test_name;
  logic [31:0] seed;

  issue_read_operands dut_i (.*);

  // 4 ns clock
  always #2 clk_i = ~clk_i;

  // ------------------------------
  // reference model
  // ------------------------------

  logic [XLEN-1:0] shadow_q [NR_REGS];
  logic            mult_q;
  logic            chk_q;
  logic [4:0]      strobe_q;
  logic [XLEN-1:0] exp_a_q;
  logic [XLEN-1:0] exp_b_q;
  logic [XLEN-1:0] exp_imm_q;
  fu_t             exp_fu_q;
  logic [OP_W-1:0] exp_op_q;
  logic [TRANS_ID_W-1:0] exp_tid_q;
  logic [XLEN-1:0] exp_pc_q;

  logic            hz_a;
  logic            fw_a;
  logic            hz_b;
  logic            fw_b;
  logic            busy;
  logic            waw_ok;
  logic            exp_stall;
  logic            exp_ack;
  logic            start;
  logic [XLEN-1:0] exp_a;
  logic [XLEN-1:0] exp_b;
  logic [4:0]      exp_strobe;

  always_comb begin
    // raw hazards, rs1 ignored for zimm forms
    hz_a = !use_zimm_i && (rd_clobber_i[rs1_i] != NONE);
    fw_a = hz_a && fwd_rs1_valid_i && (rd_clobber_i[rs1_i] != CSR);
    hz_b = rd_clobber_i[rs2_i] != NONE;
    fw_b = hz_b && fwd_rs2_valid_i && (rd_clobber_i[rs2_i] != CSR);
    exp_stall = stall_i || (hz_a && !fw_a) || (hz_b && !fw_b);
    busy = (fu_i inside {ALU, CTRL_FLOW, CSR, MULT} && !flu_ready_i) ||
           (fu_i inside {LOAD, STORE} && !lsu_ready_i);
    waw_ok = (rd_clobber_i[rd_i] == NONE) || (commit_we_i && (commit_waddr_i == rd_i));
    exp_ack = issue_valid_i &&
              ((!exp_stall && !busy && waw_ok) || ex_valid_i || (fu_i == NONE));
    // single-cycle work waits one cycle behind a multiply
    if (mult_q && (fu_i inside {ALU, CTRL_FLOW, CSR})) begin
      exp_ack = 1'b0;
    end
    // operand a: zimm, then pc, then forward, then register
    if (use_zimm_i) begin
      exp_a = XLEN'(rs1_i);
    end else if (use_pc_i) begin
      exp_a = pc_i;
    end else begin
      exp_a = fw_a ? fwd_rs1_data_i : shadow_q[rs1_i];
    end
    if (use_imm_i && !(fu_i inside {STORE, CTRL_FLOW})) begin
      exp_b = imm_i;
    end else begin
      exp_b = fw_b ? fwd_rs2_data_i : shadow_q[rs2_i];
    end
    // strobe order is alu, branch, lsu, mult, csr
    start = exp_ack && !ex_valid_i && !flush_i;
    exp_strobe = 5'b00000;
    if (start) begin
      case (fu_i)
        ALU:         exp_strobe = 5'b10000;
        CTRL_FLOW:   exp_strobe = 5'b01000;
        LOAD, STORE: exp_strobe = 5'b00100;
        MULT:        exp_strobe = 5'b00010;
        CSR:         exp_strobe = 5'b00001;
        default:     exp_strobe = 5'b00000;
      endcase
    end
  end

  // expectations for the cycle after the edge
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      for (int i = 0; i < NR_REGS; i++) begin
        shadow_q[i] <= '0;
      end
      mult_q   <= 1'b0;
      chk_q    <= 1'b0;
      strobe_q <= '0;
    end else begin
      // x0 keeps zero
      if (commit_we_i && (commit_waddr_i != '0)) begin
        shadow_q[commit_waddr_i] <= commit_wdata_i;
      end
      mult_q    <= start && (fu_i == MULT);
      chk_q     <= exp_ack;
      strobe_q  <= exp_strobe;
      exp_a_q   <= exp_a;
      exp_b_q   <= exp_b;
      exp_imm_q <= imm_i;
      exp_fu_q  <= fu_i;
      exp_op_q  <= op_i;
      exp_tid_q <= trans_id_i;
      exp_pc_q  <= pc_i;
    end
  end

  // ------------------------------
  // assertions
  // ------------------------------

  // acknowledge and stall sampled mid-cycle, inputs settled by then
  ack_check: assert property (@(negedge clk_i) disable iff (!rst_uarch_ni)
    issue_ack_o == exp_ack)
  else begin
    errors++;
    $display("Error: %s issue_ack_o expected %0b actual %0b", test_name,
             $sampled(exp_ack), $sampled(issue_ack_o));
  end

  stall_check: assert property (@(negedge clk_i) disable iff (!rst_uarch_ni)
    stall_issue_o == exp_stall)
  else begin
    errors++;
    $display("Error: %s stall_issue_o expected %0b actual %0b", test_name,
             $sampled(exp_stall), $sampled(stall_issue_o));
  end

  // every cycle, so flush and excepted entries are covered as well
  strobe_check: assert property (@(posedge clk_i) disable iff (!rst_uarch_ni)
    {alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o} == strobe_q)
  else begin
    errors++;
    $display("Error: %s strobes expected %b actual %b", test_name, $sampled(strobe_q),
             $sampled({alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o}));
  end

  opa_check: assert property (@(posedge clk_i) disable iff (!rst_uarch_ni)
    chk_q |-> operand_a_o == exp_a_q)
  else begin
    errors++;
    $display("Error: %s operand_a_o expected %h actual %h", test_name,
             $sampled(exp_a_q), $sampled(operand_a_o));
  end

  opb_check: assert property (@(posedge clk_i) disable iff (!rst_uarch_ni)
    chk_q |-> operand_b_o == exp_b_q)
  else begin
    errors++;
    $display("Error: %s operand_b_o expected %h actual %h", test_name,
             $sampled(exp_b_q), $sampled(operand_b_o));
  end

  // imm, fu, op, trans id and pc as one word
  fields_check: assert property (@(posedge clk_i) disable iff (!rst_uarch_ni)
    chk_q |-> {imm_o, fu_o, op_o, trans_id_o, pc_o} ==
              {exp_imm_q, exp_fu_q, exp_op_q, exp_tid_q, exp_pc_q})
  else begin
    errors++;
    $display("Error: %s entry fields expected %h actual %h", test_name,
             $sampled({exp_imm_q, exp_fu_q, exp_op_q, exp_tid_q, exp_pc_q}),
             $sampled({imm_o, fu_o, op_o, trans_id_o, pc_o}));
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------

  function automatic logic [XLEN-1:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // returns 1 ns after a rising edge
  task automatic next_cycle(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic commit_write(input int addr, input logic [XLEN-1:0] data);
    commit_we_i    = 1'b1;
    commit_waddr_i = REG_ADDR_W'(addr);
    commit_wdata_i = data;
    next_cycle(1);
    commit_we_i = 1'b0;
  endtask

  // new entry with random pc, imm, op and id, flags cleared
  task automatic entry(input string name, input fu_t fu, input int rs1, input int rs2,
                       input int rd);
    test_name     = name;
    fu_i          = fu;
    rs1_i         = REG_ADDR_W'(rs1);
    rs2_i         = REG_ADDR_W'(rs2);
    rd_i          = REG_ADDR_W'(rd);
    pc_i          = lcg_next();
    imm_i         = lcg_next();
    op_i          = OP_W'(lcg_next());
    trans_id_i    = TRANS_ID_W'(lcg_next());
    use_imm_i     = 1'b0;
    use_pc_i      = 1'b0;
    use_zimm_i    = 1'b0;
    ex_valid_i    = 1'b0;
    issue_valid_i = 1'b1;
  endtask

  // holds the entry until it is taken, then drops valid
  task automatic wait_ack();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!issue_ack_o && (n < 50)) begin
      @(negedge clk_i);
      n++;
    end
    if (!issue_ack_o) begin
      timeouts++;
      $display("timeout: %s was not acknowledged within 50 cycles", test_name);
    end
    next_cycle(1);
    issue_valid_i = 1'b0;
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    fu_t units [6];
    units = '{ALU, CTRL_FLOW, LOAD, STORE, MULT, CSR};
    errors = 0;
    timeouts = 0;
    seed = 32'd90965;
    test_name = "reset";
    clk_i = 1'b0;
    rst_uarch_ni = 1'b0;
    flush_i = 1'b0;
    stall_i = 1'b0;
    issue_valid_i = 1'b0;
    pc_i = '0;
    rs1_i = '0;
    rs2_i = '0;
    rd_i = '0;
    imm_i = '0;
    use_imm_i = 1'b0;
    use_pc_i = 1'b0;
    use_zimm_i = 1'b0;
    fu_i = NONE;
    op_i = '0;
    trans_id_i = '0;
    ex_valid_i = 1'b0;
    for (int i = 0; i < NR_REGS; i++) begin
      rd_clobber_i[i] = NONE;
    end
    fwd_rs1_data_i = '0;
    fwd_rs1_valid_i = 1'b0;
    fwd_rs2_data_i = '0;
    fwd_rs2_valid_i = 1'b0;
    flu_ready_i = 1'b1;
    lsu_ready_i = 1'b1;
    commit_we_i = 1'b0;
    commit_waddr_i = '0;
    commit_wdata_i = '0;

    repeat (8) @(posedge clk_i);
    reset_check: assert ({alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o,
                          csr_valid_o, operand_a_o, operand_b_o, imm_o, fu_o, op_o,
                          trans_id_o, pc_o} == {5'b0, {3{XLEN'(0)}}, NONE, OP_RESET,
                                                TRANS_ID_W'(0), XLEN'(0)})
    else begin
      errors++;
      $display("Error: %s outputs expected %h actual %h", test_name,
               {5'b0, {3{XLEN'(0)}}, NONE, OP_RESET, TRANS_ID_W'(0), XLEN'(0)},
               {alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o,
                operand_a_o, operand_b_o, imm_o, fu_o, op_o, trans_id_o, pc_o});
    end
    #1;
    rst_uarch_ni = 1'b1;
    next_cycle(1);

    // register read, x0 written too
    for (int r = 0; r < 8; r++) begin
      commit_write(r, lcg_next());
    end
    entry("regfile_read", ALU, 1, 2, 8);
    wait_ack();
    entry("regfile_read", ALU, 3, 7, 9);
    wait_ack();
    entry("x0_read", ALU, 0, 5, 10);
    wait_ack();

    // forwarding from the scoreboard
    rd_clobber_i[4] = ALU;
    fwd_rs1_valid_i = 1'b1;
    fwd_rs1_data_i = lcg_next();
    entry("fwd_rs1", ALU, 4, 2, 11);
    wait_ack();
    rd_clobber_i[2] = MULT;
    fwd_rs2_valid_i = 1'b1;
    fwd_rs2_data_i = lcg_next();
    entry("fwd_rs2", ALU, 4, 2, 11);
    wait_ack();
    rd_clobber_i[2] = NONE;
    fwd_rs1_valid_i = 1'b0;
    entry("stall_no_fwd", ALU, 4, 2, 11);
    next_cycle(3);
    fwd_rs1_valid_i = 1'b1;
    wait_ack();
    rd_clobber_i[4] = CSR;
    entry("stall_csr", ALU, 4, 2, 11);
    next_cycle(3);
    rd_clobber_i[4] = NONE;
    wait_ack();
    rd_clobber_i[4] = LOAD;
    fwd_rs1_valid_i = 1'b0;
    entry("zimm_no_stall", CSR, 4, 3, 12);
    use_zimm_i = 1'b1;
    wait_ack();
    rd_clobber_i[4] = NONE;
    entry("outer_stall", ALU, 1, 2, 12);
    stall_i = 1'b1;
    next_cycle(2);
    stall_i = 1'b0;
    wait_ack();

    // operand sources
    entry("use_pc", ALU, 1, 2, 13);
    use_pc_i = 1'b1;
    wait_ack();
    entry("zimm_over_pc", CSR, 21, 3, 13);
    use_pc_i = 1'b1;
    use_zimm_i = 1'b1;
    wait_ack();
    entry("use_imm", ALU, 1, 2, 13);
    use_imm_i = 1'b1;
    wait_ack();
    entry("store_keeps_rs2", STORE, 1, 2, 0);
    use_imm_i = 1'b1;
    wait_ack();
    entry("branch_keeps_rs2", CTRL_FLOW, 3, 5, 0);
    use_imm_i = 1'b1;
    wait_ack();

    // waw, released by a commit to rd in the same cycle
    rd_clobber_i[9] = ALU;
    entry("waw_hold", ALU, 1, 2, 9);
    next_cycle(3);
    commit_we_i = 1'b1;
    commit_waddr_i = 5'd9;
    commit_wdata_i = lcg_next();
    wait_ack();
    commit_we_i = 1'b0;
    flu_ready_i = 1'b0;
    entry("ex_valid", ALU, 1, 2, 9);
    ex_valid_i = 1'b1;
    wait_ack();
    // rd still clobbered, only the fu NONE bypass can take this one
    entry("fu_none", NONE, 1, 2, 9);
    wait_ack();
    rd_clobber_i[9] = NONE;

    // readiness
    entry("flu_busy", ALU, 1, 2, 14);
    next_cycle(3);
    flu_ready_i = 1'b1;
    wait_ack();
    lsu_ready_i = 1'b0;
    entry("lsu_busy", LOAD, 1, 0, 15);
    next_cycle(3);
    lsu_ready_i = 1'b1;
    wait_ack();

    // routing, mult directly followed by csr hits the contention rule
    foreach (units[i]) begin
      entry("routing", units[i], i + 1, i + 2, 16);
      wait_ack();
    end
    entry("mult_then_alu", MULT, 1, 2, 17);
    wait_ack();
    entry("mult_then_alu", ALU, 3, 4, 18);
    wait_ack();

    // flush in the accepting cycle
    entry("flush", ALU, 1, 2, 19);
    flush_i = 1'b1;
    wait_ack();
    entry("flush", MULT, 5, 6, 19);
    wait_ack();
    flush_i = 1'b0;
    next_cycle(3);

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- src/dispatch_regs.sv
// id/ex pipeline registers
// holds the operands and entry fields for execute and raises one
// valid strobe per functional unit one cycle after issue

module dispatch_regs import issue_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_uarch_ni,
  input  logic                  flush_i,
  input  logic                  issue_valid_i,
  input  logic                  issue_ack_i,
  input  logic                  ex_valid_i,
  input  fu_t                   fu_i,
  input  logic [OP_W-1:0]       op_i,
  input  logic [TRANS_ID_W-1:0] trans_id_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic [XLEN-1:0]       imm_i,
  output logic                  alu_valid_o,
  output logic                  branch_valid_o,
  output logic                  lsu_valid_o,
  output logic                  mult_valid_o,
  output logic                  csr_valid_o,
  output logic                  mult_pending_o,
  output logic [XLEN-1:0]       operand_a_o,
  output logic [XLEN-1:0]       operand_b_o,
  output logic [XLEN-1:0]       imm_o,
  output fu_t                   fu_o,
  output logic [OP_W-1:0]       op_o,
  output logic [TRANS_ID_W-1:0] trans_id_o,
  output logic [XLEN-1:0]       pc_o
);

  logic start;

  // entry accepted, not excepted and not flushed
  // an excepted entry just passes on to commit, no unit starts
  assign start = issue_valid_i && issue_ack_i && !ex_valid_i && !flush_i;

  // ------------------------------
  // unit strobes
  // ------------------------------

  // strobes last one cycle, cleared unless a new start hits
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      alu_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
      lsu_valid_o    <= 1'b0;
      mult_valid_o   <= 1'b0;
      csr_valid_o    <= 1'b0;
    end else begin
      alu_valid_o    <= start && (fu_i == ALU);
      branch_valid_o <= start && (fu_i == CTRL_FLOW);
      lsu_valid_o    <= start && (fu_i inside {LOAD, STORE});
      mult_valid_o   <= start && (fu_i == MULT);
      csr_valid_o    <= start && (fu_i == CSR);
    end
  end

  // the multiplier strobe doubles as the contention flag for issue
  assign mult_pending_o = mult_valid_o;

  // ------------------------------
  // id/ex payload
  // ------------------------------

  // sampled every edge, only meaningful next to a strobe
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      operand_a_o <= '0;
      operand_b_o <= '0;
      imm_o       <= '0;
      fu_o        <= NONE;
      op_o        <= OP_RESET;
      trans_id_o  <= '0;
      pc_o        <= '0;
    end else begin
      operand_a_o <= operand_a_i;
      operand_b_o <= operand_b_i;
      imm_o       <= imm_i;
      fu_o        <= fu_i;
      op_o        <= op_i;
      trans_id_o  <= trans_id_i;
      pc_o        <= pc_i;
    end
  end

endmodule

//--- src/int_regfile.sv
// integer register file
// two combinational read ports and one synchronous write port,
// x0 is hardwired to zero

module int_regfile import issue_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_uarch_ni,
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i
);

  logic [XLEN-1:0] regs_q [NR_REGS];

  // x0 has no storage, it reads as zero
  assign regs_q[0] = '0;

  // one flop word per architectural register x1..x31
  for (genvar i = 1; i < NR_REGS; i++) begin : gen_reg
    always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
      if (!rst_uarch_ni) begin
        regs_q[i] <= '0;
      end else if (we_i && (waddr_i == REG_ADDR_W'(i))) begin
        regs_q[i] <= wdata_i;
      end
    end
  end

  // read ports
  // a write shows up here in the cycle after its edge
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

//--- src/issue_gate.sv
// issue acknowledge
// unit busy check, write-after-write check and the multiplier
// contention rule on the fixed latency result bus

module issue_gate import issue_pkg::*; (
  input  logic                  issue_valid_i,
  input  fu_t                   fu_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  input  logic                  ex_valid_i,
  input  fu_t [NR_REGS-1:0]     rd_clobber_i,
  input  logic                  stall_i,
  input  logic                  flu_ready_i,
  input  logic                  lsu_ready_i,
  input  logic                  commit_we_i,
  input  logic [REG_ADDR_W-1:0] commit_waddr_i,
  input  logic                  mult_pending_i,
  output logic                  issue_ack_o
);

  logic fu_busy;
  logic rd_free;
  logic rd_commit;

  // ------------------------------
  // unit busy
  // ------------------------------

  // fixed latency units share flu_ready_i
  always_comb begin
    unique case (fu_i)
      ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~flu_ready_i;
      LOAD, STORE:               fu_busy = ~lsu_ready_i;
      default:                   fu_busy = 1'b0;
    endcase
  end

  // ------------------------------
  // waw check
  // ------------------------------

  // no older entry in flight writes rd
  assign rd_free = (rd_clobber_i[rd_i] == NONE);

  // the older writer retires this very cycle
  assign rd_commit = commit_we_i && (commit_waddr_i == rd_i);

  always_comb begin
    issue_ack_o = 1'b0;
    if (issue_valid_i) begin
      // regular path, operands ready and unit free
      if (!stall_i && !fu_busy && (rd_free || rd_commit)) begin
        issue_ack_o = 1'b1;
      end
      // excepted entries and fu NONE need no unit at all,
      // they go through even while stalled or busy
      if (ex_valid_i || (fu_i == NONE)) begin
        issue_ack_o = 1'b1;
      end
    end
    // multiply result lands one cycle late on the shared bus,
    // keep single-cycle work out of the way for a cycle
    if (mult_pending_i && (fu_i inside {ALU, CTRL_FLOW, CSR})) begin
      issue_ack_o = 1'b0;
    end
  end

endmodule

//--- src/issue_pkg.sv
// issue stage package
// widths, functional-unit encoding and reset values shared by the
// integer issue and read-operands stage

package issue_pkg;

  // ------------------------------
  // data path widths
  // ------------------------------

  // data and pc width
  localparam int unsigned XLEN = 32;

  // register index width
  localparam int unsigned REG_ADDR_W = 5;

  // number of integer registers, x0 included
  localparam int unsigned NR_REGS = 32;

  // scoreboard transaction id width
  localparam int unsigned TRANS_ID_W = 3;

  // opaque operation code, only passed through to execute
  localparam int unsigned OP_W = 7;

  // zimm sits in the rs1 field of csr immediate forms
  localparam int unsigned ZIMM_W = 5;

  // ------------------------------
  // functional units
  // ------------------------------

  // target unit of a scoreboard entry
  // also used as the clobber list entry type:
  // NONE there means no pending writer
  typedef enum logic [2:0] {
    NONE,
    LOAD,
    STORE,
    ALU,
    CTRL_FLOW,
    MULT,
    CSR
  } fu_t;

  // ------------------------------
  // reset values
  // ------------------------------

  // operation held in the id/ex register after reset
  // the add encoding, so a stray alu start does no harm
  localparam logic [OP_W-1:0] OP_RESET = '0;

endpackage

//--- src/issue_read_operands.sv
// integer issue and read-operands stage
// hazard check, register read, operand mux, issue acknowledge and the
// id/ex registers feeding the functional units

module issue_read_operands import issue_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_uarch_ni,
  input  logic                  flush_i,
  input  logic                  stall_i,
  // decoded scoreboard entry
  input  logic                  issue_valid_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [REG_ADDR_W-1:0] rs1_i,
  input  logic [REG_ADDR_W-1:0] rs2_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  input  logic [XLEN-1:0]       imm_i,
  input  logic                  use_imm_i,
  input  logic                  use_pc_i,
  input  logic                  use_zimm_i,
  input  fu_t                   fu_i,
  input  logic [OP_W-1:0]       op_i,
  input  logic [TRANS_ID_W-1:0] trans_id_i,
  input  logic                  ex_valid_i,
  output logic                  issue_ack_o,
  // scoreboard lookup
  input  fu_t [NR_REGS-1:0]     rd_clobber_i,
  input  logic [XLEN-1:0]       fwd_rs1_data_i,
  input  logic                  fwd_rs1_valid_i,
  input  logic [XLEN-1:0]       fwd_rs2_data_i,
  input  logic                  fwd_rs2_valid_i,
  // unit readiness
  input  logic                  flu_ready_i,
  input  logic                  lsu_ready_i,
  // commit write port
  input  logic                  commit_we_i,
  input  logic [REG_ADDR_W-1:0] commit_waddr_i,
  input  logic [XLEN-1:0]       commit_wdata_i,
  // to execute
  output logic                  alu_valid_o,
  output logic                  branch_valid_o,
  output logic                  lsu_valid_o,
  output logic                  mult_valid_o,
  output logic                  csr_valid_o,
  output logic [XLEN-1:0]       operand_a_o,
  output logic [XLEN-1:0]       operand_b_o,
  output logic [XLEN-1:0]       imm_o,
  output fu_t                   fu_o,
  output logic [OP_W-1:0]       op_o,
  output logic [TRANS_ID_W-1:0] trans_id_o,
  output logic [XLEN-1:0]       pc_o,
  output logic                  stall_issue_o
);

  logic            fwd_a;
  logic            fwd_b;
  logic            stall;
  logic            mult_pending;
  logic [XLEN-1:0] rdata_a;
  logic [XLEN-1:0] rdata_b;
  logic [XLEN-1:0] operand_a_n;
  logic [XLEN-1:0] operand_b_n;
  logic [XLEN-1:0] imm_n;

  // upstream stops feeding entries while operands are missing
  assign stall_issue_o = stall;

  // ------------------------------
  // operand availability
  // ------------------------------

  operand_hazard i_operand_hazard (
    .rs1_i           (rs1_i),
    .rs2_i           (rs2_i),
    .use_zimm_i      (use_zimm_i),
    .rd_clobber_i    (rd_clobber_i),
    .fwd_rs1_valid_i (fwd_rs1_valid_i),
    .fwd_rs2_valid_i (fwd_rs2_valid_i),
    .stall_i         (stall_i),
    .fwd_a_o         (fwd_a),
    .fwd_b_o         (fwd_b),
    .stall_o         (stall)
  );

  // ------------------------------
  // issue decision
  // ------------------------------

  issue_gate i_issue_gate (
    .issue_valid_i  (issue_valid_i),
    .fu_i           (fu_i),
    .rd_i           (rd_i),
    .ex_valid_i     (ex_valid_i),
    .rd_clobber_i   (rd_clobber_i),
    .stall_i        (stall),
    .flu_ready_i    (flu_ready_i),
    .lsu_ready_i    (lsu_ready_i),
    .commit_we_i    (commit_we_i),
    .commit_waddr_i (commit_waddr_i),
    .mult_pending_i (mult_pending),
    .issue_ack_o    (issue_ack_o)
  );

  // ------------------------------
  // register read and operand mux
  // ------------------------------

  // read ports addressed straight from the entry
  int_regfile i_int_regfile (
    .clk_i        (clk_i),
    .rst_uarch_ni (rst_uarch_ni),
    .raddr_a_i    (rs1_i),
    .raddr_b_i    (rs2_i),
    .rdata_a_o    (rdata_a),
    .rdata_b_o    (rdata_b),
    .we_i         (commit_we_i),
    .waddr_i      (commit_waddr_i),
    .wdata_i      (commit_wdata_i)
  );

  operand_select i_operand_select (
    .rdata_a_i      (rdata_a),
    .rdata_b_i      (rdata_b),
    .fwd_rs1_data_i (fwd_rs1_data_i),
    .fwd_rs2_data_i (fwd_rs2_data_i),
    .fwd_a_i        (fwd_a),
    .fwd_b_i        (fwd_b),
    .pc_i           (pc_i),
    .rs1_i          (rs1_i),
    .imm_i          (imm_i),
    .use_pc_i       (use_pc_i),
    .use_zimm_i     (use_zimm_i),
    .use_imm_i      (use_imm_i),
    .fu_i           (fu_i),
    .operand_a_o    (operand_a_n),
    .operand_b_o    (operand_b_n),
    .imm_o          (imm_n)
  );

  // ------------------------------
  // id/ex stage
  // ------------------------------

  dispatch_regs i_dispatch_regs (
    .clk_i          (clk_i),
    .rst_uarch_ni   (rst_uarch_ni),
    .flush_i        (flush_i),
    .issue_valid_i  (issue_valid_i),
    .issue_ack_i    (issue_ack_o),
    .ex_valid_i     (ex_valid_i),
    .fu_i           (fu_i),
    .op_i           (op_i),
    .trans_id_i     (trans_id_i),
    .pc_i           (pc_i),
    .operand_a_i    (operand_a_n),
    .operand_b_i    (operand_b_n),
    .imm_i          (imm_n),
    .alu_valid_o    (alu_valid_o),
    .branch_valid_o (branch_valid_o),
    .lsu_valid_o    (lsu_valid_o),
    .mult_valid_o   (mult_valid_o),
    .csr_valid_o    (csr_valid_o),
    .mult_pending_o (mult_pending),
    .operand_a_o    (operand_a_o),
    .operand_b_o    (operand_b_o),
    .imm_o          (imm_o),
    .fu_o           (fu_o),
    .op_o           (op_o),
    .trans_id_o     (trans_id_o),
    .pc_o           (pc_o)
  );

endmodule

//--- src/operand_hazard.sv
// read-after-write check of the source operands
// looks up rs1/rs2 in the clobber list and picks forward or stall

module operand_hazard import issue_pkg::*; (
  input  logic [REG_ADDR_W-1:0] rs1_i,
  input  logic [REG_ADDR_W-1:0] rs2_i,
  input  logic                  use_zimm_i,
  input  fu_t [NR_REGS-1:0]     rd_clobber_i,
  input  logic                  fwd_rs1_valid_i,
  input  logic                  fwd_rs2_valid_i,
  input  logic                  stall_i,
  output logic                  fwd_a_o,
  output logic                  fwd_b_o,
  output logic                  stall_o
);

  // ------------------------------
  // per-operand decision
  // ------------------------------

  // returns {forward, stall} for one source operand
  // clobber: pending writer of that register
  // avail: scoreboard already holds the result
  function automatic logic [1:0] resolve(input fu_t clobber, input logic avail);
    logic fwd;
    logic stl;
    fwd = 1'b0;
    stl = 1'b0;
    if (clobber != NONE) begin
      // csr results only come back through the register file
      if (avail && (clobber != CSR)) begin
        fwd = 1'b1;
      end else begin
        stl = 1'b1;
      end
    end
    return {fwd, stl};
  endfunction

  logic [1:0] res_a;
  logic [1:0] res_b;

  // rs1 carries zimm for csr immediate forms, nothing to wait on then
  always_comb begin
    res_a = 2'b00;
    if (!use_zimm_i) begin
      res_a = resolve(rd_clobber_i[rs1_i], fwd_rs1_valid_i);
    end
  end

  // rs2 is always checked
  assign res_b = resolve(rd_clobber_i[rs2_i], fwd_rs2_valid_i);

  // ------------------------------
  // outputs
  // ------------------------------

  assign fwd_a_o = res_a[1];
  assign fwd_b_o = res_b[1];

  // outside stall request or any operand still missing
  assign stall_o = stall_i | res_a[0] | res_b[0];

endmodule

//--- src/operand_select.sv
// operand multiplexer
// builds the next operand a, operand b and immediate of the entry

module operand_select import issue_pkg::*; (
  input  logic [XLEN-1:0]       rdata_a_i,
  input  logic [XLEN-1:0]       rdata_b_i,
  input  logic [XLEN-1:0]       fwd_rs1_data_i,
  input  logic [XLEN-1:0]       fwd_rs2_data_i,
  input  logic                  fwd_a_i,
  input  logic                  fwd_b_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [REG_ADDR_W-1:0] rs1_i,
  input  logic [XLEN-1:0]       imm_i,
  input  logic                  use_pc_i,
  input  logic                  use_zimm_i,
  input  logic                  use_imm_i,
  input  fu_t                   fu_i,
  output logic [XLEN-1:0]       operand_a_o,
  output logic [XLEN-1:0]       operand_b_o,
  output logic [XLEN-1:0]       imm_o
);

  always_comb begin
    // register file by default, scoreboard when forwarded
    operand_a_o = fwd_a_i ? fwd_rs1_data_i : rdata_a_i;
    operand_b_o = fwd_b_i ? fwd_rs2_data_i : rdata_b_i;

    // auipc, jal and friends
    if (use_pc_i) begin
      operand_a_o = pc_i;
    end
    // zimm wins over pc, zero extended
    if (use_zimm_i) begin
      operand_a_o = {{(XLEN - ZIMM_W){1'b0}}, rs1_i[ZIMM_W-1:0]};
    end

    // stores keep rs2 as data, branches keep rs2 for the compare;
    // both take their offset through imm_o instead
    if (use_imm_i && (fu_i != STORE) && (fu_i != CTRL_FLOW)) begin
      operand_b_o = imm_i;
    end
  end

  // immediate always travels on its own lane
  assign imm_o = imm_i;

endmodule
